/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= chol_tb
FILELIST  ?= list.f
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dv/chol_input.txt */
# Matrix line: name, flags, packed A as a11 a21 a22 a31 a32 a33 (Q16.16 hex)
# Result line: expected packed L as l11 l21 l22 l31 l32 l33 (Q16.16 hex)
# Flags: bit 0 resets in mid-run, bit 1 sends a second strobe while busy
ident 0 00010000 00000000 00010000 00000000 00000000 00010000
    00010000 00000000 00010000 00000000 00000000 00010000
diag 0 00040000 00000000 00020000 00000000 00000000 00090000
    00020000 00000000 00016a09 00000000 00000000 00030000
gen_int 0 00040000 000c0000 00250000 fff00000 ffd50000 00620000
    00020000 00060000 00010000 fff80000 00050000 00030000
gen_frac 0 00090000 00030000 00050000 fffa0000 00020000 00084000
    00030000 00010000 00020000 fffe0000 00020000 00008000
gen_root2 0 00020000 00010000 00020000 00000000 00010000 00020000
    00016a09 0000b505 00013988 00000000 0000d106 0001279a
mid_reset 1 00040000 000c0000 00250000 fff00000 ffd50000 00620000
    00020000 00060000 00010000 fff80000 00050000 00030000
second_strobe 2 00090000 00030000 00050000 fffa0000 00020000 00084000
    00030000 00010000 00020000 fffe0000 00020000 00008000
# Zero leading diagonal, column 1 saturates and later sums wrap
zero_lead 0 00000000 00010000 00030001 ffff0000 00030000 00090001
    00000000 7fffffff 00020000 80000001 00010000 00030000

/* dv/chol_tb_checks.svh */
`ifndef chol_tb_checks_svh
`define chol_tb_checks_svh

// Error count of the running test, test counts of the whole run
int test_errs;
int pass_count;
int fail_count;

task automatic check_fix(input string test, input int idx, input fix_t exp_val,
                         input fix_t act_val);
    if (act_val !== exp_val) begin
        $display("error %s: l[%0d] expected %h actual %h", test, idx, exp_val, act_val);
        test_errs++;
    end
endtask

task automatic check_flag(input string test, input string what, input logic exp_val,
                          input logic act_val);
    if (act_val !== exp_val) begin
        $display("error %s: %s expected %b actual %b", test, what, exp_val, act_val);
        test_errs++;
    end
endtask

// Whole packed triangle, element by element
task automatic check_tri(input string test, input logic [tri_w-1:0] exp_val,
                         input logic [tri_w-1:0] act_val);
    for (int k = 0; k < tri_n; k++) begin
        check_fix(test, k, fix_t'(exp_val[k*32 +: 32]), fix_t'(act_val[k*32 +: 32]));
    end
endtask

task automatic close_test(input string test);
    if (test_errs == 0) begin
        pass_count++;
        $display("test %s passed", test);
    end else begin
        fail_count++;
        $display("test %s failed with %0d errors", test, test_errs);
    end
endtask

`endif

/* dv/chol_tb.sv */
`timescale 1ns/1ps

module chol_tb;
    import chol_pkg::*;

    localparam int n        = 3;
    localparam int tri_n    = tri_len(n);
    localparam int tri_w    = tri_n * $bits(fix_t);
    localparam int wait_max = 2000;  // Cycles allowed per wait

    logic             clk = 1'b0;
    logic             rst;
    logic [tri_w-1:0] a;
    logic             a_valid;
    logic [tri_w-1:0] l;
    logic             l_valid;

    `include "chol_tb_checks.svh"

    chol_top #(
        .n (n)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------
    // Stimulus helpers entered and left on a falling edge
    // ------------------------------------------------------------------

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic strobe(input logic [tri_w-1:0] m);
        a       = m;
        a_valid = 1'b1;
        @(negedge clk);  // Accepted on the rising edge in between
        a_valid = 1'b0;
    endtask

    // The old result must stay on l until l_valid rises
    task automatic wait_result(input string test, input logic [tri_w-1:0] held,
                               output bit ok);
        int cycles;
        bit held_ok;
        cycles  = 0;
        held_ok = 1'b1;
        while (!l_valid && cycles < wait_max) begin
            if (held_ok && l !== held) begin
                check_tri(test, held, l);
                held_ok = 1'b0;
            end
            @(negedge clk);
            cycles++;
        end
        ok = l_valid;
        if (!ok) begin
            $display("%s: l_valid did not rise within %0d cycles", test, wait_max);
            test_errs++;
        end
    endtask

    // Next line that is neither blank nor a comment or empty at end of file
    task automatic next_line(input int fd, output string line);
        string raw;
        line = "";
        while (line == "" && !$feof(fd)) begin
            raw = "";
            void'($fgets(raw, fd));
            if (raw.len() > 1 && raw[0] != "#") begin
                line = raw;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        int               fd;
        bit               ok;
        string            line;
        string            name;
        logic [31:0]      flags;
        fix_t             a_vec [tri_n];
        fix_t             l_exp [tri_n];
        logic [tri_w-1:0] a_pk, l_pk, prev_l, decoy;

        rst        = 1'b1;
        a          = '0;
        a_valid    = 1'b0;
        ok         = 1'b1;
        pass_count = 0;
        fail_count = 0;
        prev_l     = '0;
        decoy      = '0;
        for (int r = 0; r < n; r++) begin
            decoy[(r * (r + 1) / 2 + r)*32 +: 32] = 32'h0009_0000;  // 9.0 on the diagonal
        end

        apply_reset();
        test_errs = 0;
        check_flag("reset", "l_valid", 1'b0, l_valid);
        check_tri("reset", '0, l);
        close_test("reset");

        fd = $fopen("dv/chol_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/chol_input.txt");
            fail_count++;
        end
        while (fd != 0 && ok) begin
            next_line(fd, line);
            if (line == "") begin
                break;
            end
            // Order 3 layout with name, flags and A on one line and L on the next
            if ($sscanf(line, "%s %h %h %h %h %h %h %h", name, flags, a_vec[0], a_vec[1],
                        a_vec[2], a_vec[3], a_vec[4], a_vec[5]) != 2 + tri_n) begin
                $display("malformed matrix line in vector file: %s", line);
                fail_count++;
                break;
            end
            next_line(fd, line);
            if ($sscanf(line, "%h %h %h %h %h %h", l_exp[0], l_exp[1], l_exp[2],
                        l_exp[3], l_exp[4], l_exp[5]) != tri_n) begin
                $display("malformed result line for %s in vector file", name);
                fail_count++;
                break;
            end
            for (int k = 0; k < tri_n; k++) begin
                a_pk[k*32 +: 32] = a_vec[k];
                l_pk[k*32 +: 32] = l_exp[k];
            end

            test_errs = 0;
            strobe(a_pk);
            check_flag(name, "l_valid after accept", 1'b0, l_valid);
            if (flags[0]) begin
                repeat (20) @(negedge clk);
                apply_reset();
                check_flag(name, "l_valid after reset", 1'b0, l_valid);
                check_tri(name, '0, l);
                prev_l = '0;  // Reset cleared the held result
                strobe(a_pk);
            end
            if (flags[1]) begin
                repeat (3) @(negedge clk);
                strobe(decoy);  // Must be dropped
            end
            wait_result(name, prev_l, ok);
            if (ok) begin
                check_tri(name, l_pk, l);
                repeat (2) @(negedge clk);
                check_flag(name, "l_valid while idle", 1'b1, l_valid);
                prev_l = l_pk;
            end
            close_test(name);
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 1) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+dv
rtl/chol_pkg.sv
rtl/chol_sqrt.sv
rtl/chol_div.sv
rtl/chol_seq.sv
rtl/chol_top.sv
dv/chol_tb.sv

/* rtl/chol_div.sv */
`timescale 1ns/1ps

module chol_div (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::fix_t num,
    input  chol_pkg::fix_t den,
    output chol_pkg::fix_t quot,
    output logic           done
);
    import chol_pkg::*;

    localparam int fix_w = $bits(fix_t);
    localparam int cnt_w = $clog2(div_cycles);

    logic                  busy;
    logic [cnt_w-1:0]      cnt;
    logic [fix_w-1:0]      num_mag, den_mag;
    logic [fix_w-1:0]      den_q, den_cur;
    logic [div_cycles-1:0] quo_q, quo_cur;  // Dividend bits out, quotient bits in
    logic [fix_w:0]        rem_q, rem_cur, rem_sh;
    logic                  fits;
    logic                  neg_q, num_neg_q, zero_q;
    fix_t                  quot_mag;

    assign num_mag = num[fix_w-1] ? -num : num;
    assign den_mag = den[fix_w-1] ? -den : den;

    // ------------------------------------------------------------------
    // Restoring shift-subtract step
    // ------------------------------------------------------------------

    always_comb begin
        if (start) begin
            quo_cur = div_cycles'({num_mag, {frac_bits{1'b0}}});
            rem_cur = '0;
            den_cur = den_mag;
        end else begin
            quo_cur = quo_q;
            rem_cur = rem_q;
            den_cur = den_q;
        end
        rem_sh = {rem_cur[fix_w-1:0], quo_cur[div_cycles-1]};
        fits   = rem_sh >= {1'b0, den_cur};
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            quo_q <= {quo_cur[div_cycles-2:0], fits};
            rem_q <= fits ? rem_sh - {1'b0, den_cur} : rem_sh;
            den_q <= den_cur;
        end
        if (start) begin
            neg_q     <= num[fix_w-1] ^ den[fix_w-1];
            num_neg_q <= num[fix_w-1];
            zero_q    <= (den == '0);
        end
    end

    // ------------------------------------------------------------------
    // Cycle count and done pulse
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= cnt_w'(1);
            end else if (busy) begin
                if (cnt == cnt_w'(div_cycles - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // Sign applied to the magnitude, truncates toward zero
    always_comb begin
        quot_mag = fix_t'(quo_q);
        if (zero_q) begin
            quot = num_neg_q ? -fix_max : fix_max;  // Saturate on zero divisor
        end else begin
            quot = neg_q ? -quot_mag : quot_mag;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst) busy |-> !start);
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

/* rtl/chol_pkg.sv */
package chol_pkg;

    // ------------------------------------------------------------------
    // Number formats
    // ------------------------------------------------------------------

    localparam int frac_bits = 16;

    typedef logic signed [31:0] fix_t;  // Q16.16 matrix element
    typedef logic signed [63:0] acc_t;  // Q32.32 product and running sum

    localparam fix_t fix_max = 32'sh7fff_ffff;

    // ------------------------------------------------------------------
    // Sizes and unit latencies
    // ------------------------------------------------------------------

    localparam int n_def = 3;

    localparam int sqrt_cycles = 24;  // One root bit per cycle
    localparam int div_cycles  = 48;  // One quotient bit per cycle

    // Elements in the packed lower triangle
    function automatic int tri_len(input int order);
        return order * (order + 1) / 2;
    endfunction

    // ------------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------------

    typedef enum logic [2:0] {
        s_idle,
        s_diag_acc,  // Sum of squares left of the diagonal
        s_sqrt,
        s_off_acc,   // Sum of row products below the diagonal
        s_div,
        s_done
    } seq_state_t;

endpackage

/* rtl/chol_seq.sv */
`timescale 1ns/1ps

module chol_seq #(
    parameter int n = chol_pkg::n_def
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [chol_pkg::tri_len(n)*$bits(chol_pkg::fix_t)-1:0] a,
    input  logic                                                  a_valid,
    output logic                                                  sqrt_start,
    output chol_pkg::fix_t                                        sqrt_in,
    input  chol_pkg::fix_t                                        sqrt_out,
    input  logic                                                  sqrt_done,
    output logic                                                  div_start,
    output chol_pkg::fix_t                                        div_num,
    output chol_pkg::fix_t                                        div_den,
    input  chol_pkg::fix_t                                        div_out,
    input  logic                                                  div_done,
    output logic [chol_pkg::tri_len(n)*$bits(chol_pkg::fix_t)-1:0] l,
    output logic                                                  l_valid
);
    import chol_pkg::*;

    localparam int fix_w = $bits(fix_t);
    localparam int tri_w = tri_len(n) * fix_w;
    localparam int ctr_w = $clog2(n + 1);

    typedef logic [ctr_w-1:0] ctr_t;

    seq_state_t       state;
    ctr_t             col, row, term;  // Column j, row i, product index k
    logic [tri_w-1:0] a_q, l_work;
    acc_t             acc_q, prod, rem_acc;
    fix_t             op_row, op_col, a_elem, rem_fix;
    logic             in_acc, acc_last, accept;

    // Offset of element (r, c) in the packed triangle
    function automatic int tri_idx(input int r, input int c);
        return r * (r + 1) / 2 + c;
    endfunction

    assign in_acc   = (state == s_diag_acc) || (state == s_off_acc);
    assign acc_last = in_acc && (term == col);
    assign accept   = ((state == s_idle) || (state == s_done)) && a_valid;

    // ------------------------------------------------------------------
    // Multiply-accumulate path
    // ------------------------------------------------------------------

    // Row equals col while on the diagonal, so one path serves both sums
    assign op_row  = l_work[tri_idx(row, term)*fix_w +: fix_w];
    assign op_col  = l_work[tri_idx(col, term)*fix_w +: fix_w];
    assign a_elem  = a_q[tri_idx(row, col)*fix_w +: fix_w];
    assign prod    = acc_t'(op_row) * acc_t'(op_col);
    assign rem_acc = (acc_t'(a_elem) <<< frac_bits) - acc_q;
    assign rem_fix = fix_t'(rem_acc >>> frac_bits);

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
        end
        if (!in_acc) begin
            acc_q <= '0;  // Fresh sum for every element
        end else if (!acc_last) begin
            acc_q <= acc_q + prod;
        end
        if (acc_last && state == s_diag_acc) begin
            sqrt_in <= rem_fix;
        end
        if (acc_last && state == s_off_acc) begin
            div_num <= rem_fix;
            div_den <= l_work[tri_idx(col, col)*fix_w +: fix_w];  // l_jj
        end
        if (state == s_sqrt && sqrt_done) begin
            l_work[tri_idx(col, col)*fix_w +: fix_w] <= sqrt_out;
        end
        if (state == s_div && div_done) begin
            l_work[tri_idx(row, col)*fix_w +: fix_w] <= div_out;
        end
    end

    // ------------------------------------------------------------------
    // Column FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= s_idle;
            col        <= '0;
            row        <= '0;
            term       <= '0;
            sqrt_start <= 1'b0;
            div_start  <= 1'b0;
            l          <= '0;
            l_valid    <= 1'b0;
        end else begin
            sqrt_start <= 1'b0;
            div_start  <= 1'b0;
            case (state)
                s_idle, s_done: begin
                    if (a_valid) begin
                        state   <= s_diag_acc;
                        col     <= '0;
                        row     <= '0;
                        term    <= '0;
                        l_valid <= 1'b0;
                    end
                end
                s_diag_acc, s_off_acc: begin
                    if (term == col) begin
                        if (state == s_diag_acc) begin
                            state      <= s_sqrt;
                            sqrt_start <= 1'b1;
                        end else begin
                            state     <= s_div;
                            div_start <= 1'b1;
                        end
                    end else begin
                        term <= term + 1'b1;
                    end
                end
                s_sqrt: begin
                    if (sqrt_done) begin
                        term <= '0;
                        if (col == ctr_t'(n - 1)) begin
                            state   <= s_done;
                            l       <= {sqrt_out, l_work[tri_w-fix_w-1:0]};  // l_nn on top
                            l_valid <= 1'b1;
                        end else begin
                            state <= s_off_acc;
                            row   <= col + 1'b1;
                        end
                    end
                end
                s_div: begin
                    if (div_done) begin
                        term <= '0;
                        if (row == ctr_t'(n - 1)) begin  // Column finished
                            state <= s_diag_acc;
                            col   <= col + 1'b1;
                            row   <= col + 1'b1;
                        end else begin
                            state <= s_off_acc;
                            row   <= row + 1'b1;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {s_idle, s_diag_acc, s_sqrt, s_off_acc, s_div, s_done});
    a_sqrt_start: assert property (@(posedge clk) disable iff (rst)
        sqrt_start |-> state == s_sqrt);
    a_div_start: assert property (@(posedge clk) disable iff (rst)
        div_start |-> state == s_div);

endmodule

/* rtl/chol_sqrt.sv */
`timescale 1ns/1ps

module chol_sqrt (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::fix_t radicand,
    output chol_pkg::fix_t root,
    output logic           done
);
    import chol_pkg::*;

    // Two radicand bits are consumed for every root bit
    localparam int rad_w = 2 * sqrt_cycles;
    localparam int rem_w = sqrt_cycles + 4;
    localparam int cnt_w = $clog2(sqrt_cycles);

    logic                   busy;
    logic [cnt_w-1:0]       cnt;
    logic [rad_w-1:0]       rad_q, rad_cur;
    logic [rem_w-1:0]       rem_q, rem_cur, rem_sh, trial;
    logic [sqrt_cycles-1:0] root_q, root_cur;
    logic                   fits;

    // First step runs on the start cycle itself
    always_comb begin
        if (start) begin
            rad_cur  = radicand[31] ? '0 : rad_w'({radicand, {frac_bits{1'b0}}});
            rem_cur  = '0;
            root_cur = '0;
        end else begin
            rad_cur  = rad_q;
            rem_cur  = rem_q;
            root_cur = root_q;
        end
        rem_sh = {rem_cur[rem_w-3:0], rad_cur[rad_w-1 -: 2]};
        trial  = rem_w'({root_cur, 2'b01});  // 4*root + 1
        fits   = rem_sh >= trial;
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            rad_q  <= rad_cur << 2;
            rem_q  <= fits ? rem_sh - trial : rem_sh;
            root_q <= {root_cur[sqrt_cycles-2:0], fits};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= cnt_w'(1);
            end else if (busy) begin
                if (cnt == cnt_w'(sqrt_cycles - 1)) begin  // Last bit this cycle
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    assign root = fix_t'(root_q);  // Root is below 2^24, zero extended

    // Sequencer waits for done before the next radicand
    a_no_restart: assert property (@(posedge clk) disable iff (rst) busy |-> !start);

endmodule

/* rtl/chol_top.sv */
`timescale 1ns/1ps

module chol_top #(
    parameter int n = chol_pkg::n_def
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [chol_pkg::tri_len(n)*$bits(chol_pkg::fix_t)-1:0] a,
    input  logic                                                  a_valid,
    output logic [chol_pkg::tri_len(n)*$bits(chol_pkg::fix_t)-1:0] l,
    output logic                                                  l_valid
);
    import chol_pkg::*;

    // Sequencer to square root
    logic sqrt_start, sqrt_done;
    fix_t sqrt_in, sqrt_out;

    // Sequencer to divider
    logic div_start, div_done;
    fix_t div_num, div_den, div_out;

    chol_seq #(
        .n (n)
    ) seq_i (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .a_valid    (a_valid),
        .sqrt_start (sqrt_start),
        .sqrt_in    (sqrt_in),
        .sqrt_out   (sqrt_out),
        .sqrt_done  (sqrt_done),
        .div_start  (div_start),
        .div_num    (div_num),
        .div_den    (div_den),
        .div_out    (div_out),
        .div_done   (div_done),
        .l          (l),
        .l_valid    (l_valid)
    );

    chol_sqrt sqrt_i (
        .clk      (clk),
        .rst      (rst),
        .start    (sqrt_start),
        .radicand (sqrt_in),
        .root     (sqrt_out),
        .done     (sqrt_done)
    );

    chol_div div_i (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .num   (div_num),
        .den   (div_den),
        .quot  (div_out),
        .done  (div_done)
    );

endmodule
